// File: mini_mcu.f
source/mini_mcu_pkg.sv
source/system_bus.sv
source/sram_bank.sv
source/ao_peripherals.sv
source/dma_engine.sv
source/mini_mcu.sv
tests/tb_mini_mcu.sv

// File: run.sh
#!/bin/sh
# compile and run the mini_mcu testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mini_mcu -f mini_mcu.f -o tb_mini_mcu
out=$(./obj_dir/tb_mini_mcu)
echo "$out"
if echo "$out" | grep -qx '\*\* PASS \*\*'; then
  exit 0
fi
exit 1

// File: tests/tb_mini_mcu.sv
/*
 * testbench for mini_mcu: table of host operations with a RAM and register
 * model, GPIO, exit and DMA copy checks, timeout and summary
 */
module tb_mini_mcu;

  localparam int RAM_WORDS = 128;
  localparam mini_mcu_pkg::addr_t ALIAS = 32'(RAM_WORDS * 4);
  localparam mini_mcu_pkg::addr_t PERIPH = 32'h0001_0000;
  localparam mini_mcu_pkg::addr_t SRC_BASE = 32'h0000_0100;
  localparam mini_mcu_pkg::gpio_t GPIO_PATTERN = 8'h5A;

  typedef struct packed {
    logic                we;
    mini_mcu_pkg::addr_t addr;
    mini_mcu_pkg::data_t data;
    mini_mcu_pkg::be_t   be;
    mini_mcu_pkg::data_t exp;
  } op_t;

  logic                   clk;
  logic                   rst_n;
  mini_mcu_pkg::bus_req_t host_req;
  mini_mcu_pkg::bus_rsp_t host_rsp;
  mini_mcu_pkg::gpio_t    gpio_in;
  mini_mcu_pkg::gpio_t    gpio_out;
  mini_mcu_pkg::gpio_t    gpio_oe;
  logic                   exit_valid;
  mini_mcu_pkg::data_t    exit_value;
  logic                   dma_done;

  op_t ops[$];
  int  op_total = 0;
  int  checks = 0;
  int  errors = 0;
  int  done_pulses = 0;
  int  cycles = 0;

  // reference model of RAM and registers
  mini_mcu_pkg::data_t    ram_m [RAM_WORDS];
  mini_mcu_pkg::gpio_t    m_gpio_out;
  mini_mcu_pkg::gpio_t    m_gpio_oe;
  mini_mcu_pkg::data_t    m_exit;
  mini_mcu_pkg::addr_t    m_src;
  mini_mcu_pkg::addr_t    m_dst;
  mini_mcu_pkg::dma_len_t m_len;
  logic                   m_busy;
  logic                   m_done;

  mini_mcu #(
    .RAM_WORDS(RAM_WORDS)
  ) dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .host_req_i  (host_req),
    .host_rsp_o  (host_rsp),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .exit_valid_o(exit_valid),
    .exit_value_o(exit_value),
    .dma_done_o  (dma_done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(negedge clk) begin
    if (rst_n && dma_done) begin
      done_pulses <= done_pulses + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > 40 * op_total + 2000) begin
      $display("timeout after %0d cycles, a host operation or DMA copy never finished", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic int ram_index(mini_mcu_pkg::addr_t a);
    return int'((a >> 2) % RAM_WORDS);
  endfunction

  function automatic mini_mcu_pkg::addr_t reg_addr(mini_mcu_pkg::reg_off_t off);
    return PERIPH | 32'(off);
  endfunction

  function automatic mini_mcu_pkg::data_t fill_word(mini_mcu_pkg::addr_t a);
    return (a * 32'h9E37_79B9) ^ 32'h5A5A_0000;
  endfunction

  function automatic mini_mcu_pkg::data_t merge_bytes(mini_mcu_pkg::data_t old_w,
                                                      mini_mcu_pkg::data_t new_w,
                                                      mini_mcu_pkg::be_t be);
    mini_mcu_pkg::data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic mini_mcu_pkg::data_t expected_read(mini_mcu_pkg::addr_t a);
    mini_mcu_pkg::data_t res;
    res = '0;
    if (!a[mini_mcu_pkg::PERIPH_SEL_BIT]) begin
      res = ram_m[ram_index(a)];
    end else begin
      case (a[mini_mcu_pkg::PERIPH_SEL_BIT-1:0])
        mini_mcu_pkg::REG_GPIO_OUT:   res = {24'b0, m_gpio_out};
        mini_mcu_pkg::REG_GPIO_OE:    res = {24'b0, m_gpio_oe};
        mini_mcu_pkg::REG_GPIO_IN:    res = {24'b0, GPIO_PATTERN};
        mini_mcu_pkg::REG_EXIT:       res = m_exit;
        mini_mcu_pkg::REG_DMA_SRC:    res = m_src;
        mini_mcu_pkg::REG_DMA_DST:    res = m_dst;
        mini_mcu_pkg::REG_DMA_LEN:    res = {16'b0, m_len};
        mini_mcu_pkg::REG_DMA_STATUS: res = {30'b0, m_done, m_busy};
        default:                      res = '0;
      endcase
    end
    return res;
  endfunction

  function automatic void push_write(mini_mcu_pkg::addr_t a, mini_mcu_pkg::data_t d,
                                     mini_mcu_pkg::be_t be);
    op_t                 e;
    mini_mcu_pkg::data_t len_w;
    e.we = 1'b1;
    e.addr = a;
    e.data = d;
    e.be = be;
    e.exp = '0;
    ops.push_back(e);
    op_total++;
    if (!a[mini_mcu_pkg::PERIPH_SEL_BIT]) begin
      ram_m[ram_index(a)] = merge_bytes(ram_m[ram_index(a)], d, be);
    end else begin
      case (a[mini_mcu_pkg::PERIPH_SEL_BIT-1:0])
        mini_mcu_pkg::REG_GPIO_OUT: m_gpio_out = 8'(merge_bytes({24'b0, m_gpio_out}, d, be));
        mini_mcu_pkg::REG_GPIO_OE:  m_gpio_oe = 8'(merge_bytes({24'b0, m_gpio_oe}, d, be));
        mini_mcu_pkg::REG_EXIT:     m_exit = merge_bytes(m_exit, d, be);
        mini_mcu_pkg::REG_DMA_SRC:  m_src = merge_bytes(m_src, d, be);
        mini_mcu_pkg::REG_DMA_DST:  m_dst = merge_bytes(m_dst, d, be);
        mini_mcu_pkg::REG_DMA_LEN: begin
          // a length write while busy is dropped
          if (!m_busy) begin
            len_w = merge_bytes({16'b0, m_len}, d, be);
            m_len = len_w[15:0];
            m_busy = 1'b1;
            m_done = 1'b0;
            for (int w = 0; w < int'(m_len); w++) begin
              ram_m[ram_index(m_dst + 32'(4 * w))] = ram_m[ram_index(m_src + 32'(4 * w))];
            end
          end
        end
        default: begin
        end
      endcase
    end
  endfunction

  function automatic void add_read(mini_mcu_pkg::addr_t a);
    op_t e;
    e.we = 1'b0;
    e.addr = a;
    e.data = '0;
    e.be = 4'hF;
    e.exp = expected_read(a);
    ops.push_back(e);
    op_total++;
  endfunction

  function automatic void close_copy();
    m_busy = 1'b0;
    m_done = 1'b1;
  endfunction

  task automatic check_val(input string name, input mini_mcu_pkg::data_t got,
                           input mini_mcu_pkg::data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // one host transfer, response one cycle after the grant
  task automatic host_op(input logic we, input mini_mcu_pkg::addr_t addr,
                         input mini_mcu_pkg::data_t wdata, input mini_mcu_pkg::be_t be,
                         output mini_mcu_pkg::data_t rdata);
    mini_mcu_pkg::bus_req_t r;
    r.req = 1'b1;
    r.we = we;
    r.addr = addr;
    r.wdata = wdata;
    r.be = be;
    @(posedge clk);
    host_req <= r;
    @(negedge clk);
    while (!host_rsp.gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
    host_req <= '0;
    @(negedge clk);
    check_val("host_rsp_o.rvalid", 32'(host_rsp.rvalid), 32'd1);
    rdata = host_rsp.rdata;
  endtask

  task automatic run_table();
    mini_mcu_pkg::data_t got;
    foreach (ops[i]) begin
      host_op(ops[i].we, ops[i].addr, ops[i].data, ops[i].be, got);
      check_val("host_rsp_o.rdata", got, ops[i].exp);
    end
    ops.delete();
  endtask

  task automatic wait_dma_done();
    mini_mcu_pkg::data_t st;
    st = '0;
    while (!st[1]) begin
      host_op(1'b0, reg_addr(mini_mcu_pkg::REG_DMA_STATUS), '0, 4'hF, st);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    host_req = '0;
    gpio_in = GPIO_PATTERN;
    m_gpio_out = '0;
    m_gpio_oe = '0;
    m_exit = '0;
    m_src = '0;
    m_dst = '0;
    m_len = '0;
    m_busy = 1'b0;
    m_done = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // outputs right after reset
    check_val("host_rsp_o.gnt", 32'(host_rsp.gnt), 32'd0);
    check_val("host_rsp_o.rvalid", 32'(host_rsp.rvalid), 32'd0);
    check_val("gpio_o", 32'(gpio_out), 32'd0);
    check_val("gpio_oe_o", 32'(gpio_oe), 32'd0);
    check_val("exit_valid_o", 32'(exit_valid), 32'd0);
    check_val("exit_value_o", exit_value, 32'd0);
    check_val("dma_done_o", 32'(dma_done), 32'd0);
    check_val("dma request", 32'(dut_i.dma_req.req), 32'd0);
    add_read(reg_addr(mini_mcu_pkg::REG_GPIO_OUT));
    add_read(reg_addr(mini_mcu_pkg::REG_GPIO_OE));

    // byte merges and aliasing
    push_write(32'h10, 32'h1122_3344, 4'hF);
    push_write(32'h10, 32'hAABB_CCDD, 4'b0101);
    add_read(32'h10);
    push_write(32'h14, 32'h0, 4'hF);
    push_write(32'h14, 32'h1234_5678, 4'b1100);
    add_read(32'h14);
    push_write(32'h20 + ALIAS, 32'hCAFE_F00D, 4'hF);
    add_read(32'h20);
    push_write(32'h20, 32'h0000_7700, 4'b0010);
    add_read(32'h20 + 2 * ALIAS);

    // GPIO, unmapped offset, exit
    push_write(reg_addr(mini_mcu_pkg::REG_GPIO_OUT), 32'h0000_00A5, 4'hF);
    push_write(reg_addr(mini_mcu_pkg::REG_GPIO_OE), 32'hFFFF_FF0F, 4'b0001);
    push_write(reg_addr(mini_mcu_pkg::REG_GPIO_IN), 32'h0000_00FF, 4'hF);
    add_read(reg_addr(mini_mcu_pkg::REG_GPIO_OUT));
    add_read(reg_addr(mini_mcu_pkg::REG_GPIO_OE));
    add_read(reg_addr(mini_mcu_pkg::REG_GPIO_IN));
    add_read(reg_addr(16'h40));
    push_write(reg_addr(mini_mcu_pkg::REG_EXIT), 32'h0000_0042, 4'hF);
    add_read(reg_addr(mini_mcu_pkg::REG_EXIT));
    run_table();
    check_val("gpio_o", 32'(gpio_out), 32'(m_gpio_out));
    check_val("gpio_oe_o", 32'(gpio_oe), 32'(m_gpio_oe));
    check_val("exit_valid_o", 32'(exit_valid), 32'd1);
    check_val("exit_value_o", exit_value, m_exit);

    // 8-word copy while the host polls the status
    for (int i = 0; i < 8; i++) begin
      push_write(SRC_BASE + 32'(4 * i), fill_word(SRC_BASE + 32'(4 * i)), 4'hF);
    end
    push_write(reg_addr(mini_mcu_pkg::REG_DMA_SRC), SRC_BASE, 4'hF);
    push_write(reg_addr(mini_mcu_pkg::REG_DMA_DST), 32'h180, 4'hF);
    push_write(reg_addr(mini_mcu_pkg::REG_DMA_LEN), 32'd8, 4'hF);
    run_table();
    wait_dma_done();
    close_copy();
    add_read(reg_addr(mini_mcu_pkg::REG_DMA_STATUS));
    for (int i = 0; i < 8; i++) begin
      add_read(32'h180 + 32'(4 * i));
      add_read(SRC_BASE + 32'(4 * i));
    end
    run_table();
    check_val("dma_done_o pulse count", 32'(done_pulses), 32'd1);

    // second start while busy must be dropped
    for (int i = 0; i < 8; i++) begin
      push_write(32'h1E0 + 32'(4 * i), fill_word(32'h1E0 + 32'(4 * i)), 4'hF);
    end
    push_write(reg_addr(mini_mcu_pkg::REG_DMA_DST), 32'h1C0, 4'hF);
    push_write(reg_addr(mini_mcu_pkg::REG_DMA_LEN), 32'd8, 4'hF);
    push_write(reg_addr(mini_mcu_pkg::REG_DMA_DST), 32'h1E0, 4'hF);
    push_write(reg_addr(mini_mcu_pkg::REG_DMA_LEN), 32'd8, 4'hF);
    run_table();
    wait_dma_done();
    close_copy();
    add_read(reg_addr(mini_mcu_pkg::REG_DMA_STATUS));
    for (int i = 0; i < 8; i++) begin
      add_read(32'h1C0 + 32'(4 * i));
      add_read(32'h1E0 + 32'(4 * i));
    end
    add_read(reg_addr(mini_mcu_pkg::REG_DMA_STATUS));
    run_table();
    check_val("dma_done_o pulse count", 32'(done_pulses), 32'd2);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: source/mini_mcu.sv
/*
 * top level: host port and DMA master on a shared bus,
 * SRAM bank and always-on peripheral block as slaves
 */
module mini_mcu #(
  parameter int RAM_WORDS = mini_mcu_pkg::RAM_WORDS_DEFAULT
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::bus_req_t host_req_i,
  output mini_mcu_pkg::bus_rsp_t host_rsp_o,
  input  mini_mcu_pkg::gpio_t    gpio_i,
  output mini_mcu_pkg::gpio_t    gpio_o,
  output mini_mcu_pkg::gpio_t    gpio_oe_o,
  output logic                   exit_valid_o,
  output mini_mcu_pkg::data_t    exit_value_o,
  output logic                   dma_done_o
);

  mini_mcu_pkg::bus_req_t dma_req;
  mini_mcu_pkg::bus_rsp_t dma_rsp;
  mini_mcu_pkg::bus_req_t ram_req;
  mini_mcu_pkg::bus_req_t periph_req;
  mini_mcu_pkg::data_t    ram_rdata;
  mini_mcu_pkg::data_t    periph_rdata;
  mini_mcu_pkg::dma_cfg_t dma_cfg;
  logic                   dma_done;

  assign dma_done_o = dma_done;

  system_bus system_bus_i (
    .clk_i,
    .rst_n_i,
    .host_req_i,
    .dma_req_i     (dma_req),
    .host_rsp_o,
    .dma_rsp_o     (dma_rsp),
    .ram_req_o     (ram_req),
    .periph_req_o  (periph_req),
    .ram_rdata_i   (ram_rdata),
    .periph_rdata_i(periph_rdata)
  );

  sram_bank #(
    .RAM_WORDS(RAM_WORDS)
  ) sram_bank_i (
    .clk_i,
    .rst_n_i,
    .req_i  (ram_req),
    .rdata_o(ram_rdata)
  );

  ao_peripherals ao_peripherals_i (
    .clk_i,
    .rst_n_i,
    .req_i     (periph_req),
    .rdata_o   (periph_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .exit_valid_o,
    .exit_value_o,
    .dma_cfg_o (dma_cfg),
    .dma_done_i(dma_done)
  );

  dma_engine dma_engine_i (
    .clk_i,
    .rst_n_i,
    .cfg_i    (dma_cfg),
    .bus_req_o(dma_req),
    .bus_rsp_i(dma_rsp),
    .done_o   (dma_done)
  );

endmodule

// File: source/dma_engine.sv
/*
 * DMA master: word-by-word copy from source to destination, done pulse at the end
 */
module dma_engine (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::dma_cfg_t cfg_i,
  output mini_mcu_pkg::bus_req_t bus_req_o,
  input  mini_mcu_pkg::bus_rsp_t bus_rsp_i,
  output logic                   done_o
);

  mini_mcu_pkg::dma_state_e state_q;
  mini_mcu_pkg::addr_t      src_q;
  mini_mcu_pkg::addr_t      dst_q;
  mini_mcu_pkg::dma_len_t   cnt_q;
  mini_mcu_pkg::data_t      word_q;
  logic                     done_q;

  always_comb begin
    bus_req_o.req   = ((state_q == mini_mcu_pkg::DMA_READ) && (cnt_q != '0)) ||
                      (state_q == mini_mcu_pkg::DMA_WRITE);
    bus_req_o.we    = (state_q == mini_mcu_pkg::DMA_WRITE);
    bus_req_o.addr  = (state_q == mini_mcu_pkg::DMA_WRITE) ? dst_q : src_q;
    bus_req_o.wdata = (state_q == mini_mcu_pkg::DMA_WRITE) ? word_q : '0;
    bus_req_o.be    = '1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= mini_mcu_pkg::DMA_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        mini_mcu_pkg::DMA_IDLE: begin
          if (cfg_i.start) begin
            state_q <= mini_mcu_pkg::DMA_READ;
            cnt_q   <= cfg_i.len;
          end
        end
        // nothing left to copy ends the transfer here
        mini_mcu_pkg::DMA_READ: begin
          if (cnt_q == '0) begin
            state_q <= mini_mcu_pkg::DMA_IDLE;
            done_q  <= 1'b1;
          end else if (bus_rsp_i.gnt) begin
            state_q <= mini_mcu_pkg::DMA_WAIT_R;
          end
        end
        mini_mcu_pkg::DMA_WAIT_R: begin
          if (bus_rsp_i.rvalid) begin
            state_q <= mini_mcu_pkg::DMA_WRITE;
          end
        end
        mini_mcu_pkg::DMA_WRITE: begin
          if (bus_rsp_i.gnt) begin
            state_q <= mini_mcu_pkg::DMA_WAIT_W;
          end
        end
        mini_mcu_pkg::DMA_WAIT_W: begin
          if (bus_rsp_i.rvalid) begin
            state_q <= mini_mcu_pkg::DMA_READ;
            cnt_q   <= cnt_q - 1'b1;
          end
        end
        default: state_q <= mini_mcu_pkg::DMA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == mini_mcu_pkg::DMA_IDLE && cfg_i.start) begin
      src_q <= cfg_i.src;
      dst_q <= cfg_i.dst;
    end else if (state_q == mini_mcu_pkg::DMA_WAIT_W && bus_rsp_i.rvalid) begin
      src_q <= src_q + 32'd4;
      dst_q <= dst_q + 32'd4;
    end
    if (state_q == mini_mcu_pkg::DMA_WAIT_R && bus_rsp_i.rvalid) begin
      word_q <= bus_rsp_i.rdata;
    end
  end

  assign done_o = done_q;

  // done follows a zero-length start or the response to the last write
  a_done_after_copy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |-> $past(cfg_i.start && cfg_i.len == '0, 2) ||
               $past(state_q == mini_mcu_pkg::DMA_WAIT_W && cnt_q == 16'd1 &&
                     bus_rsp_i.rvalid, 2));

endmodule

// File: source/ao_peripherals.sv
/*
 * always-on registers: GPIO out, enable and synchronized input,
 * exit value, DMA configuration and status
 */
module ao_peripherals (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::bus_req_t req_i,
  output mini_mcu_pkg::data_t    rdata_o,
  input  mini_mcu_pkg::gpio_t    gpio_i,
  output mini_mcu_pkg::gpio_t    gpio_o,
  output mini_mcu_pkg::gpio_t    gpio_oe_o,
  output logic                   exit_valid_o,
  output mini_mcu_pkg::data_t    exit_value_o,
  output mini_mcu_pkg::dma_cfg_t dma_cfg_o,
  input  logic                   dma_done_i
);

  mini_mcu_pkg::reg_off_t offset;
  logic                   wr_en;
  logic                   rd_en;
  logic                   start;
  mini_mcu_pkg::gpio_t    gpio_out_q;
  mini_mcu_pkg::gpio_t    gpio_oe_q;
  mini_mcu_pkg::gpio_t    gpio_meta_q;
  mini_mcu_pkg::gpio_t    gpio_sync_q;
  logic                   exit_valid_q;
  mini_mcu_pkg::data_t    exit_value_q;
  mini_mcu_pkg::addr_t    dma_src_q;
  mini_mcu_pkg::addr_t    dma_dst_q;
  mini_mcu_pkg::dma_len_t dma_len_q;
  mini_mcu_pkg::data_t    len_word;
  logic                   busy_q;
  logic                   done_q;

  function automatic mini_mcu_pkg::data_t merge_be(mini_mcu_pkg::data_t old_w,
                                                   mini_mcu_pkg::data_t new_w,
                                                   mini_mcu_pkg::be_t be);
    mini_mcu_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < $bits(mini_mcu_pkg::be_t); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign offset = req_i.addr[mini_mcu_pkg::PERIPH_SEL_BIT-1:0];
  assign wr_en = req_i.req && req_i.we;
  assign rd_en = req_i.req && !req_i.we;
  assign len_word = merge_be({16'b0, dma_len_q}, req_i.wdata, req_i.be);

  // start in the cycle of the length write and only when idle
  assign start = wr_en && (offset == mini_mcu_pkg::REG_DMA_LEN) && !busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_out_q   <= '0;
      gpio_oe_q    <= '0;
      gpio_meta_q  <= '0;
      gpio_sync_q  <= '0;
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      if (wr_en) begin
        case (offset)
          mini_mcu_pkg::REG_GPIO_OUT: begin
            gpio_out_q <= 8'(merge_be({24'b0, gpio_out_q}, req_i.wdata, req_i.be));
          end
          mini_mcu_pkg::REG_GPIO_OE: begin
            gpio_oe_q <= 8'(merge_be({24'b0, gpio_oe_q}, req_i.wdata, req_i.be));
          end
          mini_mcu_pkg::REG_EXIT: begin
            exit_value_q <= merge_be(exit_value_q, req_i.wdata, req_i.be);
            exit_valid_q <= 1'b1;
          end
          default: begin
          end
        endcase
      end
      // done stays set until the next start
      if (start) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (dma_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && offset == mini_mcu_pkg::REG_DMA_SRC) begin
      dma_src_q <= merge_be(dma_src_q, req_i.wdata, req_i.be);
    end
    if (wr_en && offset == mini_mcu_pkg::REG_DMA_DST) begin
      dma_dst_q <= merge_be(dma_dst_q, req_i.wdata, req_i.be);
    end
    if (start) begin
      dma_len_q <= len_word[15:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (offset)
        mini_mcu_pkg::REG_GPIO_OUT:   rdata_o <= {24'b0, gpio_out_q};
        mini_mcu_pkg::REG_GPIO_OE:    rdata_o <= {24'b0, gpio_oe_q};
        mini_mcu_pkg::REG_GPIO_IN:    rdata_o <= {24'b0, gpio_sync_q};
        mini_mcu_pkg::REG_EXIT:       rdata_o <= exit_value_q;
        mini_mcu_pkg::REG_DMA_SRC:    rdata_o <= dma_src_q;
        mini_mcu_pkg::REG_DMA_DST:    rdata_o <= dma_dst_q;
        mini_mcu_pkg::REG_DMA_LEN:    rdata_o <= {16'b0, dma_len_q};
        mini_mcu_pkg::REG_DMA_STATUS: rdata_o <= {30'b0, done_q, busy_q};
        default:                      rdata_o <= '0;
      endcase
    end
  end

  assign gpio_o = gpio_out_q;
  assign gpio_oe_o = gpio_oe_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  always_comb begin
    dma_cfg_o.src   = dma_src_q;
    dma_cfg_o.dst   = dma_dst_q;
    dma_cfg_o.len   = start ? len_word[15:0] : dma_len_q;
    dma_cfg_o.start = start;
  end

endmodule

// File: source/sram_bank.sv
/*
 * word-addressed SRAM with byte enables, registered read data
 */
module sram_bank #(
  parameter int RAM_WORDS = mini_mcu_pkg::RAM_WORDS_DEFAULT
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::bus_req_t req_i,
  output mini_mcu_pkg::data_t    rdata_o
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int NUM_BYTES = $bits(mini_mcu_pkg::be_t);

  mini_mcu_pkg::data_t mem [RAM_WORDS];
  logic [IDX_W-1:0]    word_idx;

  // addresses wrap around the bank depth
  assign word_idx = IDX_W'((req_i.addr >> 2) % RAM_WORDS);

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (req_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[word_idx];
      end
    end
  end

  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.req |-> !$isunknown(req_i.addr));

endmodule

// File: source/system_bus.sv
/*
 * shared bus: round-robin arbiter for host and DMA, address decoder,
 * response routing back to the owning master
 */
module system_bus (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::bus_req_t host_req_i,
  input  mini_mcu_pkg::bus_req_t dma_req_i,
  output mini_mcu_pkg::bus_rsp_t host_rsp_o,
  output mini_mcu_pkg::bus_rsp_t dma_rsp_o,
  output mini_mcu_pkg::bus_req_t ram_req_o,
  output mini_mcu_pkg::bus_req_t periph_req_o,
  input  mini_mcu_pkg::data_t    ram_rdata_i,
  input  mini_mcu_pkg::data_t    periph_rdata_i
);

  mini_mcu_pkg::master_e  last_grant_q;
  mini_mcu_pkg::master_e  winner;
  mini_mcu_pkg::bus_req_t win_req;
  logic                   any_req;
  logic                   to_periph;
  logic                   rsp_valid_q;
  mini_mcu_pkg::master_e  rsp_owner_q;
  logic                   rsp_periph_q;
  logic                   rsp_read_q;
  mini_mcu_pkg::data_t    rsp_rdata;

  // on contention the master not granted last wins
  always_comb begin
    if (host_req_i.req && dma_req_i.req) begin
      if (last_grant_q == mini_mcu_pkg::MST_HOST) begin
        winner = mini_mcu_pkg::MST_DMA;
      end else begin
        winner = mini_mcu_pkg::MST_HOST;
      end
    end else if (dma_req_i.req) begin
      winner = mini_mcu_pkg::MST_DMA;
    end else begin
      winner = mini_mcu_pkg::MST_HOST;
    end
  end

  assign any_req = host_req_i.req | dma_req_i.req;
  assign win_req = (winner == mini_mcu_pkg::MST_DMA) ? dma_req_i : host_req_i;
  assign to_periph = win_req.addr[mini_mcu_pkg::PERIPH_SEL_BIT];

  always_comb begin
    ram_req_o = win_req;
    ram_req_o.req = any_req && !to_periph;
    periph_req_o = win_req;
    periph_req_o.req = any_req && to_periph;
  end

  // both slaves answer one cycle after acceptance
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_grant_q <= mini_mcu_pkg::MST_DMA;
      rsp_valid_q  <= 1'b0;
      rsp_owner_q  <= mini_mcu_pkg::MST_HOST;
      rsp_periph_q <= 1'b0;
      rsp_read_q   <= 1'b0;
    end else begin
      rsp_valid_q <= any_req;
      if (any_req) begin
        last_grant_q <= winner;
        rsp_owner_q  <= winner;
        rsp_periph_q <= to_periph;
        rsp_read_q   <= !win_req.we;
      end
    end
  end

  // writes return zero data
  assign rsp_rdata = !rsp_read_q ? '0 : (rsp_periph_q ? periph_rdata_i : ram_rdata_i);

  always_comb begin
    host_rsp_o.gnt    = any_req && (winner == mini_mcu_pkg::MST_HOST);
    host_rsp_o.rvalid = rsp_valid_q && (rsp_owner_q == mini_mcu_pkg::MST_HOST);
    host_rsp_o.rdata  = (rsp_owner_q == mini_mcu_pkg::MST_HOST) ? rsp_rdata : '0;
    dma_rsp_o.gnt     = any_req && (winner == mini_mcu_pkg::MST_DMA);
    dma_rsp_o.rvalid  = rsp_valid_q && (rsp_owner_q == mini_mcu_pkg::MST_DMA);
    dma_rsp_o.rdata   = (rsp_owner_q == mini_mcu_pkg::MST_DMA) ? rsp_rdata : '0;
  end

  // a master left waiting wins in the next cycle
  a_host_no_starve: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_req_i.req && !host_rsp_o.gnt |=> !host_req_i.req || host_rsp_o.gnt);

  a_dma_no_starve: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_req_i.req && !dma_rsp_o.gnt |=> !dma_req_i.req || dma_rsp_o.gnt);

endmodule

// File: source/mini_mcu_pkg.sv
/*
 * bus widths, request and response structs, DMA config and FSM states,
 * memory map select bit and peripheral register offsets
 */
package mini_mcu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] be_t;
  typedef logic [7:0] gpio_t;
  typedef logic [15:0] dma_len_t;

  typedef enum logic [0:0] {
    MST_HOST = 1'b0,
    MST_DMA  = 1'b1
  } master_e;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    addr_t    src;
    addr_t    dst;
    dma_len_t len;
    logic     start;
  } dma_cfg_t;

  typedef enum logic [2:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WAIT_R,
    DMA_WRITE,
    DMA_WAIT_W
  } dma_state_e;

  // address bit 16 set selects the peripheral block
  localparam int PERIPH_SEL_BIT = 16;
  localparam int RAM_WORDS_DEFAULT = 256;

  typedef logic [PERIPH_SEL_BIT-1:0] reg_off_t;

  localparam reg_off_t REG_GPIO_OUT = 'h00;
  localparam reg_off_t REG_GPIO_OE = 'h04;
  localparam reg_off_t REG_GPIO_IN = 'h08;
  localparam reg_off_t REG_EXIT = 'h0C;
  localparam reg_off_t REG_DMA_SRC = 'h10;
  localparam reg_off_t REG_DMA_DST = 'h14;
  localparam reg_off_t REG_DMA_LEN = 'h18;
  localparam reg_off_t REG_DMA_STATUS = 'h1C;

endpackage
